// ==== sim.f ====
+incdir+.
fetch_pkg.sv
uop_pkg.sv
inst_decoder.sv
decode_excp_unit.sv
decode_stage_reg.sv
decode_top.sv
decode_tb.sv

// ==== Bender.yml ====
package:
  name: la_decode

export_include_dirs:
  - .

sources:
  - files:
      - fetch_pkg.sv
      - uop_pkg.sv
      - inst_decoder.sv
      - decode_excp_unit.sv
      - decode_stage_reg.sv
      - decode_top.sv
  - target: test
    files:
      - decode_tb.sv

// ==== decode_input.txt ====
# id plv_we plv_wdata stall flush valid inst pc fetch_exc | expected: valid itype cond rd rj rk imm excode
# all hex, excode 0 none 1 fetch 2 ine 3 ipe 4 sys 5 brk
1 0 0 0 0 1 001018a4 00001000 00 1 400 0 04 05 06 00000000 0
1 0 0 0 0 1 00112507 00001004 00 1 400 2 07 08 09 00000000 0
1 0 0 0 0 1 0018316a 00001008 00 1 400 d 0a 0b 0c 00000000 0
2 0 0 0 0 1 02bffca4 0000100c 00 1 400 0 04 05 00 ffffffff 0
2 0 0 0 0 1 036000e6 00001010 00 1 400 9 06 07 00 00000800 0
2 0 0 0 0 1 15000028 00001014 00 1 400 0 08 00 00 80001000 0
2 0 0 0 0 1 1c000209 00001018 00 1 400 0 09 00 00 00010000 0
2 0 0 0 0 1 28bfe16a 0000101c 00 1 004 2 0a 0b 00 fffffff8 0
2 0 0 0 0 1 200009ac 00001020 00 1 004 2 0c 0d 00 00000008 0
2 0 0 0 0 1 5bfff885 00001024 00 1 001 6 00 04 05 fffffffe 0
2 0 0 0 0 1 57fff3ff 00001028 00 1 001 5 01 00 00 fffffffc 0
3 0 0 0 0 1 298010e6 0000102c 00 1 004 6 00 07 06 00000004 0
3 0 0 0 0 1 5c00112a 00001030 00 1 001 7 00 09 0a 00000004 0
3 0 0 0 0 1 540400a0 00001034 00 1 001 5 01 00 00 00a00100 0
3 0 0 0 0 1 4c000883 00001038 00 1 001 3 03 04 00 00000002 0
4 0 0 0 0 1 000000a4 0000103c 00 1 000 0 04 05 00 00000000 2
4 0 0 0 0 1 801018a4 00001040 00 1 000 0 04 05 06 00000000 2
4 0 0 0 0 1 002b0000 00001044 00 1 000 0 00 00 00 00000000 4
4 0 0 0 0 1 002a0000 00001048 00 1 000 0 00 00 00 00000000 5
4 1 3 0 0 1 04000404 0000104c 00 1 008 0 04 00 04 00000001 0
4 1 0 0 0 1 04000404 00001050 00 1 008 0 04 00 04 00000001 3
4 0 0 0 0 1 04000404 00001054 00 1 008 0 04 00 04 00000001 0
4 0 0 0 0 1 000000a4 00001058 08 1 000 0 04 05 00 00000000 1
4 0 0 0 0 1 001018a4 0000105c 01 1 000 0 04 05 06 00000000 1
5 0 0 0 0 1 00112507 00001060 00 1 400 2 07 08 09 00000000 0
5 0 0 1 0 1 0018316a 00001064 00 1 400 2 07 08 09 00000000 0
5 0 0 0 1 1 001018a4 00001068 00 0 400 0 04 05 06 00000000 0
5 0 0 0 0 1 001018a4 0000106c 00 1 400 0 04 05 06 00000000 0
5 0 0 1 1 1 00112507 00001070 00 0 400 0 04 05 06 00000000 0
5 0 0 0 0 0 00112507 00001074 00 0 000 2 07 08 09 00000000 0

// ==== decode_tb.sv ====
// self-checking testbench that replays the vectors in decode_input.txt against decode_top
`timescale 1ns/1ps
`default_nettype none

`include "la_decode_settings.svh"

module decode_tb;

    localparam int clk_period = 40;

    // one line of decode_input.txt
    typedef struct packed {
        logic [7:0]           test_id;
        logic                 plv_we;
        logic [1:0]           plv_wdata;
        logic                 stall;
        logic                 flush;
        logic                 valid;
        logic [`LA_XLEN-1:0]  inst;
        logic [`LA_XLEN-1:0]  pc;
        logic [`LA_EXC_W-1:0] fetch_exc;
        logic                 exp_valid;
        logic [10:0]          exp_itype;
        logic [3:0]           exp_cond;
        logic [`LA_REG_W-1:0] exp_rd;
        logic [`LA_REG_W-1:0] exp_rj;
        logic [`LA_REG_W-1:0] exp_rk;
        logic [`LA_XLEN-1:0]  exp_imm;
        logic [2:0]           exp_excode;
    } vector_t;

    logic                     clk;
    logic                     rst_n;
    logic                     stall;
    logic                     flush;
    logic                     plv_we;
    logic [1:0]               plv_wdata;
    fetch_pkg::fetch_packet_t fetch_in;
    uop_pkg::decoded_t        issue_out;

    vector_t vectors[$];
    vector_t held_vec;
    int      num_vec;
    bit      loaded;
    int      test_errors;
    int      total_errors;
    int      tests_ok;
    int      tests_bad;
    int      vec_in_test;

    decode_top decode_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_in  (fetch_in),
        .stall     (stall),
        .flush     (flush),
        .plv_we    (plv_we),
        .plv_wdata (plv_wdata),
        .issue_out (issue_out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // vector file
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] col [0:16];
        vector_t     v;
        fd = $fopen("decode_input.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open decode_input.txt");
            total_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // skip comment lines
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                        col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                        col[15], col[16]);
                    if (n == 17) begin
                        v.test_id    = col[0][7:0];
                        v.plv_we     = col[1][0];
                        v.plv_wdata  = col[2][1:0];
                        v.stall      = col[3][0];
                        v.flush      = col[4][0];
                        v.valid      = col[5][0];
                        v.inst       = col[6];
                        v.pc         = col[7];
                        v.fetch_exc  = col[8][`LA_EXC_W-1:0];
                        v.exp_valid  = col[9][0];
                        v.exp_itype  = col[10][10:0];
                        v.exp_cond   = col[11][3:0];
                        v.exp_rd     = col[12][`LA_REG_W-1:0];
                        v.exp_rj     = col[13][`LA_REG_W-1:0];
                        v.exp_rk     = col[14][`LA_REG_W-1:0];
                        v.exp_imm    = col[15];
                        v.exp_excode = col[16][2:0];
                        vectors.push_back(v);
                    end else if (n > 0) begin
                        $display("error: malformed line in decode_input.txt: %s", line);
                        total_errors++;
                    end
                end
            end
            $fclose(fd);
        end
        num_vec = vectors.size();
    endtask

    task automatic drive_inputs(input vector_t v);
        plv_we             = v.plv_we;
        plv_wdata          = v.plv_wdata;
        stall              = v.stall;
        flush              = v.flush;
        fetch_in.valid     = v.valid;
        fetch_in.unknown   = 1'b0;
        fetch_in.badv      = v.pc;
        fetch_in.exception = v.fetch_exc;
        fetch_in.pc_next   = v.pc + 32'd4;
        fetch_in.pc        = v.pc;
        fetch_in.inst.raw  = v.inst;
    endtask

    //////////////////////////////////////////////////
    // checking and reporting
    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic compare_outputs(input vector_t v, input vector_t h);
        check_field("valid", issue_out.valid, v.exp_valid);
        check_field("itype", issue_out.uop.itype, v.exp_itype);
        check_field("cond", issue_out.uop.cond, v.exp_cond);
        check_field("rd", issue_out.uop.rd, v.exp_rd);
        check_field("rj", issue_out.uop.rj, v.exp_rj);
        check_field("rk", issue_out.uop.rk, v.exp_rk);
        check_field("imm", issue_out.uop.imm, v.exp_imm);
        check_field("excode", issue_out.excode, v.exp_excode);
        // pass-through fields follow the last packet the register loaded
        check_field("pc", issue_out.uop.pc, h.pc);
        check_field("orig_inst", issue_out.uop.orig_inst, h.inst);
        check_field("fetch_exc", issue_out.fetch_exc, h.fetch_exc);
        check_field("badv", issue_out.badv, h.pc);
    endtask

    task automatic report_test(input logic [7:0] id);
        if (test_errors == 0) begin
            $display("test %0d: %0d vectors, ok", id, vec_in_test);
            tests_ok++;
        end else begin
            $display("test %0d: %0d vectors, %0d mismatches", id, vec_in_test, test_errors);
            tests_bad++;
        end
        total_errors += test_errors;
        test_errors = 0;
        vec_in_test = 0;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    initial begin
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        plv_we = 1'b0;
        plv_wdata = 2'd0;
        fetch_in = '0;
        test_errors = 0;
        total_errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        vec_in_test = 0;
        load_vectors();
        loaded = 1'b1;
        if (num_vec == 0) begin
            $display("error: no vectors were read from decode_input.txt");
            total_errors++;
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // nothing may issue straight out of reset
        assert (issue_out.valid === 1'b0) else begin
            $display("Mismatch at %0t ns: valid is %0b after reset, expected 0",
                     $time, issue_out.valid);
            total_errors++;
        end
        // outputs checked 1 ns after each edge
        // next inputs driven 2 ns after it
        for (int i = 0; i < num_vec; i++) begin
            drive_inputs(vectors[i]);
            @(posedge clk);
            #1;
            // payload only loads when stall was low at the edge
            if (!vectors[i].stall)
                held_vec = vectors[i];
            compare_outputs(vectors[i], held_vec);
            vec_in_test++;
            if (i == num_vec - 1 || vectors[i + 1].test_id != vectors[i].test_id)
                report_test(vectors[i].test_id);
            #1;
        end
        fetch_in.valid = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        plv_we = 1'b0;
        $display("summary: %0d tests ok, %0d tests with mismatches", tests_ok, tests_bad);
        if (total_errors == 0 && tests_bad == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // watchdog budget grows with the vector count
    initial begin
        wait (loaded);
        #((num_vec + 10) * clk_period);
        $display("error: watchdog timeout, the run did not end within %0d cycles",
                 num_vec + 10);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== decode_top.sv ====
// decode stage top, connects decoder, exception unit and the issue register
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  fetch_pkg::fetch_packet_t fetch_in,
    input  logic                     stall,
    input  logic                     flush,
    input  logic                     plv_we,
    input  logic [1:0]               plv_wdata,
    output uop_pkg::decoded_t        issue_out
);
    uop_pkg::uop_t    uop;
    uop_pkg::excode_e excode;
    logic invalid, is_syscall, is_break, is_privileged;

    inst_decoder inst_decoder_i (
        .fetch_in      (fetch_in),
        .uop           (uop),
        .invalid       (invalid),
        .is_syscall    (is_syscall),
        .is_break      (is_break),
        .is_privileged (is_privileged)
    );

    decode_excp_unit decode_excp_unit_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .plv_we        (plv_we),
        .plv_wdata     (plv_wdata),
        .valid         (fetch_in.valid),
        .invalid       (invalid),
        .is_syscall    (is_syscall),
        .is_break      (is_break),
        .is_privileged (is_privileged),
        .fetch_exc     (fetch_in.exception),
        .excode        (excode)
    );

    decode_stage_reg decode_stage_reg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .valid     (fetch_in.valid),
        .uop       (uop),
        .excode    (excode),
        .fetch_exc (fetch_in.exception),
        .badv      (fetch_in.badv),
        .issue_out (issue_out)
    );

endmodule

`default_nettype wire

// ==== decode_stage_reg.sv ====
// decode to issue pipeline register that holds on stall and drops valid on flush
`timescale 1ns/1ps
`default_nettype none

`include "la_decode_settings.svh"

module decode_stage_reg (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 valid,
    input  uop_pkg::uop_t        uop,
    input  uop_pkg::excode_e     excode,
    input  logic [`LA_EXC_W-1:0] fetch_exc,
    input  logic [`LA_XLEN-1:0]  badv,
    output uop_pkg::decoded_t    issue_out
);

    // payload moves whenever the stage is not stalled
    // flush wins over stall and clears valid only
    always_ff @(posedge clk) begin
        if (!stall) begin
            issue_out <= '{valid: valid, uop: uop, excode: excode,
                           fetch_exc: fetch_exc, badv: badv};
        end
        if (!rst_n || flush) begin
            issue_out.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== decode_excp_unit.sv ====
// privilege level register and exception selection for the instruction in decode
`timescale 1ns/1ps
`default_nettype none

`include "la_decode_settings.svh"

module decode_excp_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 plv_we,
    input  logic [1:0]           plv_wdata,
    input  logic                 valid,
    input  logic                 invalid,
    input  logic                 is_syscall,
    input  logic                 is_break,
    input  logic                 is_privileged,
    input  logic [`LA_EXC_W-1:0] fetch_exc,
    output uop_pkg::excode_e     excode
);
    logic [`LA_PLV_W-1:0] plv;
    logic                 user_mode;

    // software write, visible from the next edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            plv <= '0;
        end else if (plv_we) begin
            plv <= plv_wdata;
        end
    end

    assign user_mode = plv == `LA_PLV_USER;

    //////////////////////////////////////////////////
    // fixed priority, fetch first
    always_comb begin
        excode = uop_pkg::exc_none;
        if (valid) begin
            if (fetch_exc != '0)
                excode = uop_pkg::exc_fetch;
            else if (invalid)
                excode = uop_pkg::exc_ine;
            else if (is_privileged && user_mode)
                excode = uop_pkg::exc_ipe;
            else if (is_syscall)
                excode = uop_pkg::exc_sys;
            else if (is_break)
                excode = uop_pkg::exc_brk;
        end
    end

endmodule

`default_nettype wire

// ==== inst_decoder.sv ====
// combinational decoder turning one fetch packet into a micro-op and exception flags
`timescale 1ns/1ps
`default_nettype none

`include "la_decode_settings.svh"

module inst_decoder (
    input  fetch_pkg::fetch_packet_t fetch_in,
    output uop_pkg::uop_t            uop,
    output logic                     invalid,
    output logic                     is_syscall,
    output logic                     is_break,
    output logic                     is_privileged
);
    logic [`LA_XLEN-1:0]  inst;
    logic [`LA_REG_W-1:0] f_rd, f_rj, f_rk;
    logic [`LA_REG_W-1:0] rd, rj, rk;
    logic [`LA_XLEN-1:0]  imm;
    uop_pkg::itype_t      itype;
    logic is_b_or_bl, is_jirl, is_preload, is_pcadd, is_lui, is_alu_imm;
    logic is_invtlb, is_ecall, is_alu_sfti, is_sra, is_time, is_alu;
    logic mem_write, mem_atm, sign;
    uop_pkg::src1_e   src1;
    uop_pkg::src2_e   src2;
    uop_pkg::alu_op_e alu_op;
    logic             alu_op_invalid;
    logic             br_invalid;
    logic [3:0]       cond;

    assign inst = fetch_in.inst.raw;
    assign f_rd = fetch_in.inst.fmt_3r.rd;
    assign f_rj = fetch_in.inst.fmt_3r.rj;
    assign f_rk = fetch_in.inst.fmt_3r.rk;

    //////////////////////////////////////////////////
    // class match
    assign itype[uop_pkg::itype_br]    = inst[30];
    assign itype[uop_pkg::itype_bar]   = inst[30:16] == 15'b011100001110010;
    assign itype[uop_pkg::itype_mem]   = inst[30:28] == 3'b010;
    assign itype[uop_pkg::itype_csr]   = inst[30:24] == 7'b0000100;
    assign itype[uop_pkg::itype_cache] = inst[30:22] == 9'b000011000;
    assign itype[uop_pkg::itype_idle]  = inst[30:15] == 16'b0000110010010001;
    assign itype[uop_pkg::itype_eret]  = inst[30:10] == 21'b000011001001000001110;
    assign itype[uop_pkg::itype_tlb]   = is_invtlb ||
        (inst[30:13] == 18'b000011001001000001 && inst[12:10] != 3'b110);
    assign itype[uop_pkg::itype_mul]   = inst[30:17] == 14'b00000000001110;
    assign itype[uop_pkg::itype_div]   = inst[30:17] == 14'b00000000010000;
    assign itype[uop_pkg::itype_alu]   = is_alu || is_time || is_sra || is_alu_sfti ||
        is_alu_imm || is_pcadd || is_lui;

    assign is_b_or_bl  = inst[30:27] == 4'b1010;
    assign is_jirl     = inst[30:26] == 5'b10011;
    assign is_preload  = inst[30:22] == 9'b010101011;
    assign is_pcadd    = inst[30:25] == 6'b001110;
    assign is_lui      = inst[30:25] == 6'b001010;
    assign is_alu_imm  = inst[30:25] == 6'b000001;
    assign is_invtlb   = inst[30:15] == 16'b0000110010010011;
    assign is_ecall    = inst[30:17] == 14'b00000000010101 && !inst[15];
    assign is_alu_sfti = inst[30:20] == 11'b00000000100 && inst[17:15] == 3'b001;
    assign is_sra      = inst[30:15] == 16'b0000000000110000;
    assign is_time     = inst[30:11] == 20'b00000000000000001100;
    assign is_alu      = inst[30:19] == 12'b000000000010;

    assign is_syscall = is_ecall && inst[16];
    assign is_break   = is_ecall && !inst[16];

    // hit-type cacop (code[4:3] == 2) is allowed in user mode
    assign is_privileged = (itype[uop_pkg::itype_cache] && inst[4:3] != 2'd2) ||
        itype[uop_pkg::itype_tlb] || itype[uop_pkg::itype_csr] ||
        itype[uop_pkg::itype_eret] || itype[uop_pkg::itype_idle];

    //////////////////////////////////////////////////
    // operand sources and operation
    always_comb begin
        if (is_lui) src1 = uop_pkg::src1_zero;
        else if (is_pcadd) src1 = uop_pkg::src1_pc;
        else if (is_time && !inst[10] && f_rd == '0) src1 = uop_pkg::src1_cntid;
        else src1 = uop_pkg::src1_rf;

        if (is_alu_imm || is_alu_sfti || is_lui || is_pcadd) src2 = uop_pkg::src2_imm;
        else if (is_time && !inst[10] && f_rd != '0) src2 = uop_pkg::src2_cntl;
        else if (is_time) src2 = uop_pkg::src2_cnth;
        else src2 = uop_pkg::src2_rf;
    end

    always_comb begin
        alu_op_invalid = 1'b0;
        alu_op = uop_pkg::alu_add;
        if (is_alu) begin
            alu_op = uop_pkg::alu_op_e'(inst[18:15]);
        end else if (is_alu_imm) begin
            case (inst[24:22])
                3'b000: alu_op = uop_pkg::alu_slt;
                3'b001: alu_op = uop_pkg::alu_sltu;
                3'b010: alu_op = uop_pkg::alu_add;
                3'b101: alu_op = uop_pkg::alu_and;
                3'b110: alu_op = uop_pkg::alu_or;
                3'b111: alu_op = uop_pkg::alu_xor;
                default: alu_op_invalid = 1'b1;
            endcase
        end else if (is_alu_sfti) begin
            case (inst[19:18])
                2'b00: alu_op = uop_pkg::alu_sll;
                2'b01: alu_op = uop_pkg::alu_srl;
                2'b10: alu_op = uop_pkg::alu_sra;
                default: alu_op_invalid = 1'b1;
            endcase
        end else if (is_sra) begin
            alu_op = uop_pkg::alu_sra;
        end
    end

    // jirl, b, bl, beq .. bgeu sit at 3..11
    assign br_invalid = itype[uop_pkg::itype_br] &&
        (inst[29:26] < 4'd3 || inst[29:26] > 4'd11);

    assign mem_write = inst[24];
    assign mem_atm   = ~inst[27];
    assign sign = ((itype[uop_pkg::itype_mul] || itype[uop_pkg::itype_div]) && !inst[16]) ||
        (itype[uop_pkg::itype_mem] && !inst[25]);

    always_comb begin
        cond = '0;
        if (itype[uop_pkg::itype_alu]) cond = alu_op;
        else if (itype[uop_pkg::itype_div]) cond = {3'b0, inst[15]};
        else if (itype[uop_pkg::itype_mul]) cond = {3'b0, inst[15] | inst[16]};
        // ll/sc are always word wide
        else if (itype[uop_pkg::itype_mem]) cond = {1'b0, inst[24], mem_atm ? 2'b10 : inst[23:22]};
        else if (itype[uop_pkg::itype_br]) cond = inst[29:26];
    end

    // any fetch exception also marks the word invalid
    assign invalid = (itype == '0 && !is_ecall) || alu_op_invalid || br_invalid ||
        inst[31] || (is_invtlb && f_rd > 5'd6) || fetch_in.exception != '0;

    //////////////////////////////////////////////////
    // register remap so sources sit in rj and rk
    always_comb begin
        if (itype[uop_pkg::itype_cache] || itype[uop_pkg::itype_tlb] ||
            itype[uop_pkg::itype_idle] || is_preload ||
            (itype[uop_pkg::itype_mem] && mem_write && !mem_atm) ||
            (itype[uop_pkg::itype_br] && !is_jirl && inst[29:26] != 4'b0101))
            rd = '0;
        else if (inst[30:26] == 5'b10101)
            rd = 5'd1;
        else
            rd = f_rd | ({`LA_REG_W{is_time}} & f_rj);

        if ((itype[uop_pkg::itype_tlb] && !is_invtlb) || itype[uop_pkg::itype_idle] ||
            is_pcadd || is_lui || is_b_or_bl || is_time)
            rj = '0;
        else
            rj = f_rj;

        if (is_alu || is_sra || itype[uop_pkg::itype_mul] || itype[uop_pkg::itype_div] ||
            is_invtlb)
            rk = f_rk;
        else if ((itype[uop_pkg::itype_mem] && mem_write) || itype[uop_pkg::itype_csr] ||
            (itype[uop_pkg::itype_br] && !(is_b_or_bl || is_jirl)))
            rk = f_rd;
        else
            rk = '0;
    end

    //////////////////////////////////////////////////
    // immediate formats
    // u5 shifts reuse the i12 form
    always_comb begin
        if (itype[uop_pkg::itype_cache] || (is_alu_imm && !inst[24]) ||
            (itype[uop_pkg::itype_mem] && inst[27]) || is_alu_sfti)
            imm = {{20{inst[21]}}, inst[21:10]};
        else if (is_alu_imm)
            imm = {20'b0, inst[21:10]};
        else if (itype[uop_pkg::itype_csr])
            imm = {{18{inst[23]}}, inst[23:10]};
        else if (itype[uop_pkg::itype_mem])
            imm = {{16{inst[23]}}, inst[23:10], 2'b0};
        else if (itype[uop_pkg::itype_br] && !is_b_or_bl)
            imm = {{16{inst[25]}}, inst[25:10]};
        else if (is_b_or_bl)
            imm = {{6{inst[9]}}, inst[9:0], inst[25:10]};
        else if (is_pcadd || is_lui)
            imm = {inst[24:5], 12'b0};
        else
            imm = '0;
    end

    always_comb begin
        uop.itype     = (!fetch_in.valid || invalid) ? '0 : itype;
        uop.src1      = src1;
        uop.src2      = src2;
        uop.cond      = cond;
        uop.sign      = sign;
        uop.mem_atm   = mem_atm;
        uop.rd        = rd;
        uop.rj        = rj;
        uop.rk        = rk;
        uop.imm       = imm;
        uop.pc        = fetch_in.pc;
        uop.orig_inst = inst;
    end

endmodule

`default_nettype wire

// ==== uop_pkg.sv ====
// micro-op and exception types shared by decode and issue, used by scoped name
`default_nettype none

`include "la_decode_settings.svh"

package uop_pkg;

    // bit positions inside the one-hot class vector
    typedef enum logic [3:0] {
        itype_br    = 4'd0,
        itype_bar   = 4'd1,
        itype_mem   = 4'd2,
        itype_csr   = 4'd3,
        itype_cache = 4'd4,
        itype_idle  = 4'd5,
        itype_eret  = 4'd6,
        itype_tlb   = 4'd7,
        itype_mul   = 4'd8,
        itype_div   = 4'd9,
        itype_alu   = 4'd10
    } itype_e;

    typedef logic [itype_alu:0] itype_t;

    typedef enum logic [1:0] {src1_rf, src1_pc, src1_zero, src1_cntid} src1_e;
    typedef enum logic [1:0] {src2_rf, src2_imm, src2_cntl, src2_cnth} src2_e;

    // 3R alu ops map straight from inst[18:15], sra gets a free slot
    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h2,
        alu_slt  = 4'h4,
        alu_sltu = 4'h5,
        alu_nor  = 4'h8,
        alu_and  = 4'h9,
        alu_or   = 4'ha,
        alu_xor  = 4'hb,
        alu_sra  = 4'hd,
        alu_sll  = 4'he,
        alu_srl  = 4'hf
    } alu_op_e;

    typedef struct packed {
        itype_t              itype;
        src1_e               src1;
        src2_e               src2;
        // alu op, branch condition or {0, write, width}
        logic [3:0]          cond;
        logic                sign;
        logic                mem_atm;
        logic [`LA_REG_W-1:0] rd;
        logic [`LA_REG_W-1:0] rj;
        logic [`LA_REG_W-1:0] rk;
        logic [`LA_XLEN-1:0] imm;
        logic [`LA_XLEN-1:0] pc;
        logic [`LA_XLEN-1:0] orig_inst;
    } uop_t;

    typedef enum logic [2:0] {
        exc_none, exc_fetch, exc_ine, exc_ipe, exc_sys, exc_brk
    } excode_e;

    typedef struct packed {
        logic                 valid;
        uop_t                 uop;
        excode_e              excode;
        logic [`LA_EXC_W-1:0] fetch_exc;
        logic [`LA_XLEN-1:0]  badv;
    } decoded_t;

endpackage

`default_nettype wire

// ==== fetch_pkg.sv ====
// types for the packet that fetch hands to decode, used by scoped name
`default_nettype none

`include "la_decode_settings.svh"

package fetch_pkg;

    // 3R view of the instruction word
    typedef struct packed {
        logic [`LA_XLEN-3*`LA_REG_W-1:0] opcode;
        logic [`LA_REG_W-1:0]            rk;
        logic [`LA_REG_W-1:0]            rj;
        logic [`LA_REG_W-1:0]            rd;
    } inst_3r_t;

    // raw for opcode matching, fmt_3r for register fields
    typedef union packed {
        logic [`LA_XLEN-1:0] raw;
        inst_3r_t            fmt_3r;
    } inst_word_u;

    typedef struct packed {
        logic                 valid;
        logic                 unknown;
        logic [`LA_XLEN-1:0]  badv;
        logic [`LA_EXC_W-1:0] exception;
        logic [`LA_XLEN-1:0]  pc_next;
        logic [`LA_XLEN-1:0]  pc;
        inst_word_u           inst;
    } fetch_packet_t;

endpackage

`default_nettype wire

// ==== la_decode_settings.svh ====
// width macros shared by the decode packages and modules, pulled in with `include
`ifndef LA_DECODE_SETTINGS_SVH
`define LA_DECODE_SETTINGS_SVH

// machine word, also pc and badv width
`define LA_XLEN 32

// fetch exception code carried in the fetch packet
`define LA_EXC_W 7

// architectural register number
`define LA_REG_W 5

// privilege level register
`define LA_PLV_W 2

// plv 3 is user mode, plv 0 is kernel
`define LA_PLV_USER 2'd3

`endif
